// File: flist.f
verilog/uart_pkg.sv
verilog/uart_tx_framer.sv
verilog/uart_rx_deframer.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_bridge.sv
bench/uart_bridge_checker.sv
bench/tb_uart_bridge.sv

// File: bench/tb_uart_bridge.sv
`default_nettype none
`timescale 1ns/10ps

module tb_uart_bridge;

  import uart_pkg::*;

  localparam int clks_per_bit      = 16;
  localparam int resp_timeout_bits = 32;
  localparam int num_rows          = 9;
  localparam int wait_limit        = 4000;

  typedef enum logic [1:0] {
    RESP_NONE,
    RESP_GOOD,
    RESP_BAD_PAR,
    RESP_BAD_STOP
  } resp_mode_t;

  typedef struct packed {
    cmd_word_t  cmd;
    resp_mode_t mode;
    byte_t      resp;
    logic       rand_resp;
    logic       inject;
  } row_t;

  logic      clk;
  logic      rst_n;
  cmd_word_t cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      rx;
  logic      tx;
  byte_t     read_data;
  logic      read_rdy;
  logic      read_err;

  row_t      rows [0:num_rows-1];
  logic [31:0] lcg_state;
  byte_t     exp_read_data;
  int        errors;
  int        rdy_pulses;
  int        err_pulses;

  uart_bridge #(
    .clks_per_bit     (clks_per_bit),
    .resp_timeout_bits(resp_timeout_bits)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // pulse counters on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      rdy_pulses <= 0;
      err_pulses <= 0;
    end else begin
      if (read_rdy) rdy_pulses <= rdy_pulses + 1;
      if (read_err) err_pulses <= err_pulses + 1;
    end
  end

  function automatic byte_t lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // parity bit that makes the count of ones odd
  function automatic logic odd_parity(input byte_t d);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (d[i]) ones++;
    end
    return (ones % 2 == 0);
  endfunction

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic set_row(input int idx, input cmd_word_t cmd, input resp_mode_t mode,
                         input byte_t resp, input logic rnd, input logic inj);
    rows[idx] = '{cmd: cmd, mode: mode, resp: resp, rand_resp: rnd, inject: inj};
  endtask

  // serial model of the far end receiver
  task automatic recv_frame(output byte_t data, output logic ok);
    int n;
    logic [9:0] bits;
    n = 0;
    ok = 1'b0;
    data = '0;
    while (tx === 1'b1 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) begin
      $display("timeout while waiting for a start bit on tx at %0t", $time);
      errors++;
    end else begin
      repeat (clks_per_bit / 2) @(negedge clk);
      check_flag("tx start bit", 1'b0, tx);
      for (int i = 0; i < 10; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        bits[i] = tx;
      end
      data = bits[7:0];
      check_flag("tx parity bit", odd_parity(data), bits[8]);
      check_flag("tx stop bit", 1'b1, bits[9]);
      ok = 1'b1;
    end
  endtask

  task automatic send_resp(input byte_t data, input resp_mode_t mode);
    logic [10:0] bits;
    bits = {mode != RESP_BAD_STOP, odd_parity(data) ^ (mode == RESP_BAD_PAR), data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx = bits[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic check_quiet(input int idx);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 3 * clks_per_bit; n++) begin
      @(negedge clk);
      if (tx !== 1'b1) seen = 1'b1;
    end
    if (seen) begin
      $display("unexpected frame on tx after row %0d at %0t", idx, $time);
      errors++;
    end
  endtask

  task automatic apply_row(input int idx);
    row_t  r;
    byte_t resp;
    byte_t got;
    logic  ok;
    int    n;
    int    rdy0;
    int    err0;
    r = rows[idx];
    resp = r.rand_resp ? lcg_byte() : r.resp;
    rdy0 = rdy_pulses;
    err0 = err_pulses;
    n = 0;
    while (!cmd_rdy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      $display("timeout while waiting for cmd_rdy before row %0d", idx);
      errors++;
    end
    cmd_in = r.cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    fork
      begin
        n = 0;
        while (!cmd_rdy && n < wait_limit) begin
          @(negedge clk);
          n++;
          // stray strobe with a different word while busy
          cmd_vld = r.inject && (n == 40);
          if (cmd_vld) cmd_in = ~r.cmd;
        end
        if (!cmd_rdy) begin
          $display("timeout while waiting for command end in row %0d", idx);
          errors++;
        end
      end
      begin
        recv_frame(got, ok);
        if (ok) check_byte("tx command byte", {r.cmd[15], r.cmd[14:8]}, got);
        if (r.cmd[15]) begin
          recv_frame(got, ok);
          if (ok) check_byte("tx data byte", r.cmd[7:0], got);
        end else if (r.mode != RESP_NONE) begin
          repeat (2 * clks_per_bit) @(negedge clk);
          send_resp(resp, r.mode);
        end
      end
    join
    @(negedge clk);
    if (r.cmd[15]) begin
      check_count("write cycles", 22 * clks_per_bit + 3, n);
      check_count("read_rdy pulses", 0, rdy_pulses - rdy0);
      check_count("read_err pulses", 0, err_pulses - err0);
    end else if (r.mode == RESP_GOOD) begin
      exp_read_data = resp;
      check_count("read_rdy pulses", 1, rdy_pulses - rdy0);
      check_count("read_err pulses", 0, err_pulses - err0);
    end else begin
      if (r.mode == RESP_NONE) begin
        // command frame, then the full response window
        check_count("timeout cycles", (11 + resp_timeout_bits) * clks_per_bit + 2, n);
      end
      check_count("read_rdy pulses", 0, rdy_pulses - rdy0);
      check_count("read_err pulses", 1, err_pulses - err0);
    end
    check_byte("read_data", exp_read_data, read_data);
    check_flag("cmd_rdy", 1'b1, cmd_rdy);
    check_quiet(idx);
  endtask

  initial begin
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    lcg_state = 32'h4caf38d0;
    exp_read_data = '0;
    errors = 0;

    set_row(0, 16'h92a5, RESP_NONE, 8'h00, 1'b0, 1'b0);
    set_row(1, 16'h1200, RESP_GOOD, 8'h3c, 1'b0, 1'b0);
    set_row(2, 16'h0500, RESP_GOOD, 8'h00, 1'b1, 1'b0);
    set_row(3, 16'hff00, RESP_NONE, 8'h00, 1'b0, 1'b1);
    set_row(4, 16'h2100, RESP_BAD_PAR, 8'h81, 1'b0, 1'b0);
    set_row(5, 16'h2200, RESP_BAD_STOP, 8'h7e, 1'b0, 1'b0);
    // nobody answers this one
    set_row(6, 16'h3300, RESP_NONE, 8'h00, 1'b0, 1'b0);
    set_row(7, 16'h3400, RESP_GOOD, 8'h00, 1'b1, 1'b1);
    set_row(8, 16'h81ff, RESP_NONE, 8'h00, 1'b0, 1'b0);

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("tx", 1'b1, tx);
    check_flag("cmd_rdy", 1'b1, cmd_rdy);
    check_flag("read_rdy", 1'b0, read_rdy);
    check_flag("read_err", 1'b0, read_err);
    check_byte("read_data", 8'h00, read_data);

    for (int i = 0; i < num_rows; i++) begin
      apply_row(i);
    end

    $display("rows applied: %0d, errors: %0d, assertion failures: %0d",
             num_rows, errors, uut.u_chk.fail_count);
    if (errors == 0 && uut.u_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/uart_bridge_checker.sv
`default_nettype none
`timescale 1ns/10ps

module uart_bridge_checker (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  cmd_rdy,
  input wire logic                  read_rdy,
  input wire logic                  read_err,
  input wire logic                  tx,
  input wire logic                  tx_busy,
  input wire uart_pkg::ctrl_state_t state
);

  import uart_pkg::*;

  // number of assertion failures so far
  int fail_count = 0;

  // a command in flight blocks new ones
  a_rdy_low_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> !cmd_rdy)
    else begin
      $error("cmd_rdy high outside IDLE");
      fail_count++;
    end

  a_rdy_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err))
    else begin
      $error("read_rdy and read_err high together");
      fail_count++;
    end

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      $error("read_rdy longer than one cycle");
      fail_count++;
    end

  a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_err |=> !read_err)
    else begin
      $error("read_err longer than one cycle");
      fail_count++;
    end

  // idle line stays high
  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else begin
      $error("tx low while framer idle");
      fail_count++;
    end

endmodule

bind uart_bridge uart_bridge_checker u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_rdy (cmd_rdy),
  .read_rdy(read_rdy),
  .read_err(read_err),
  .tx      (tx),
  .tx_busy (u_tx.tx_busy),
  .state   (u_ctrl.state)
);

`default_nettype wire

// File: verilog/uart_bridge.sv
`default_nettype none
`timescale 1ns/10ps

module uart_bridge #(
  parameter int clks_per_bit      = 434,
  parameter int resp_timeout_bits = 32
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_pkg::cmd_word_t cmd_in,
  input  wire logic                cmd_vld,
  output logic                     cmd_rdy,
  input  wire logic                rx,
  output logic                     tx,
  output uart_pkg::byte_t          read_data,
  output logic                     read_rdy,
  output logic                     read_err
);

  import uart_pkg::*;

  logic      tx_start;
  byte_t     tx_byte;
  logic      tx_busy;
  logic      tx_done;
  logic      rx_valid;
  rx_frame_t rx_frame;

  uart_cmd_ctrl #(
    .resp_timeout_bits(resp_timeout_bits),
    .clks_per_bit     (clks_per_bit)
  ) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  uart_tx_framer #(
    .clks_per_bit(clks_per_bit)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy),
    .tx_done (tx_done)
  );

  // always listening, controller decides what to keep
  uart_rx_deframer #(
    .clks_per_bit(clks_per_bit)
  ) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_valid(rx_valid),
    .rx_frame(rx_frame)
  );

endmodule

`default_nettype wire

// File: verilog/uart_cmd_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_ctrl #(
  parameter int resp_timeout_bits = 32,
  parameter int clks_per_bit      = 434
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_pkg::cmd_word_t cmd_in,
  input  wire logic                cmd_vld,
  input  wire logic                tx_busy,
  input  wire logic                tx_done,
  input  wire logic                rx_valid,
  input  wire uart_pkg::rx_frame_t rx_frame,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_pkg::byte_t          tx_byte,
  output uart_pkg::byte_t          read_data,
  output logic                     read_rdy,
  output logic                     read_err
);

  import uart_pkg::*;

  localparam int timeout_clks = resp_timeout_bits * clks_per_bit;
  localparam int tmr_w        = (timeout_clks > 1) ? $clog2(timeout_clks) : 1;
  localparam logic [tmr_w-1:0] tmr_last = tmr_w'(timeout_clks - 1);

  ctrl_state_t      state;
  cmd_t             cmd_q;
  logic             cmd_sent;
  logic [tmr_w-1:0] timer;
  logic             accept;
  logic             resp_good;

  assign accept    = (state == IDLE) && cmd_vld && cmd_rdy;
  assign resp_good = rx_frame.parity_ok && rx_frame.stop_ok;

  // command byte first, data byte only on writes
  assign tx_byte = (state == SEND_DATA) ? cmd_q.data : {cmd_q.write, cmd_q.addr};

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_t'(cmd_in);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      cmd_sent  <= 1'b0;
      timer     <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state    <= SEND_CMD;
            cmd_rdy  <= 1'b0;
            cmd_sent <= 1'b0;
          end
        end
        SEND_CMD: begin
          if (!cmd_sent && !tx_busy) begin
            tx_start <= 1'b1;
            cmd_sent <= 1'b1;
          end else if (tx_done) begin
            if (cmd_q.write) begin
              // framer is free again on this edge
              state    <= SEND_DATA;
              tx_start <= 1'b1;
            end else begin
              state <= WAIT_RESP;
              timer <= '0;
            end
          end
        end
        SEND_DATA: begin
          if (tx_done) begin
            state   <= IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        WAIT_RESP: begin
          if (rx_valid) begin
            state   <= IDLE;
            cmd_rdy <= 1'b1;
            if (resp_good) begin
              read_data <= rx_frame.data;
              read_rdy  <= 1'b1;
            end else begin
              read_err <= 1'b1;
            end
          end else if (timer == tmr_last) begin
            // nobody answered
            state    <= IDLE;
            cmd_rdy  <= 1'b1;
            read_err <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          state   <= IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_rx_deframer.sv
`default_nettype none
`timescale 1ns/10ps

module uart_rx_deframer #(
  parameter int clks_per_bit = 434
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          rx,
  output logic               rx_valid,
  output uart_pkg::rx_frame_t rx_frame
);

  import uart_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

  // middle of the start bit, measured from the detected edge
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'((clks_per_bit / 2) - 1);

  localparam logic [3:0] parity_idx = 4'd9;
  localparam logic [3:0] stop_idx   = 4'd10;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;

  logic             active;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic             sample;

  byte_t            shreg;
  logic             par_bit;

  // two-flop synchronizer, plus one more stage for the edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // mid-bit for start, then a whole bit time between samples
  assign sample = (bit_idx == 4'd0) ? (baud_cnt == half_cnt) : (baud_cnt == last_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        if (fall) begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync) begin
          // start bit gone high again, treat as glitch
          active <= 1'b0;
        end else if (bit_idx == stop_idx) begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge clk) begin
    if (active && sample) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
        shreg <= {rx_sync, shreg[7:1]};
      end
      if (bit_idx == parity_idx) begin
        par_bit <= rx_sync;
      end
      if (bit_idx == stop_idx) begin
        rx_frame.data      <= shreg;
        // odd count of ones over data and parity
        rx_frame.parity_ok <= ^{shreg, par_bit};
        rx_frame.stop_ok   <= rx_sync;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_tx_framer.sv
`default_nettype none
`timescale 1ns/10ps

module uart_tx_framer #(
  parameter int clks_per_bit = 434
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            tx_start,
  input  wire uart_pkg::byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy,
  output logic                 tx_done
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

  // index of the stop bit, counting the start bit as 0
  localparam logic [3:0] stop_idx = 4'd10;

  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_idx;

  // bits still to go after the start bit: data, parity, stop
  logic [9:0]       shreg;

  logic             bit_end;

  assign bit_end = (baud_cnt == last_cnt);

  // last clock of the stop bit
  assign tx_done = tx_busy && bit_end && (bit_idx == stop_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // start bit goes out right away
        tx       <= 1'b0;
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_idx == stop_idx) begin
        tx_busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= shreg[0];
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // payload shift register
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      // odd parity over the data byte
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    end else if (tx_busy && bit_end && (bit_idx != stop_idx)) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // one frame payload
  typedef logic [7:0] byte_t;

  // register address inside the command word
  typedef logic [6:0] addr_t;

  // raw command as seen on cmd_in
  typedef logic [15:0] cmd_word_t;

  // bit 15 write, 14..8 address, 7..0 write data
  typedef struct packed {
    logic  write;
    addr_t addr;
    byte_t data;
  } cmd_t;

  // one received frame plus its checks
  typedef struct packed {
    byte_t data;
    logic  parity_ok;
    logic  stop_ok;
  } rx_frame_t;

  // command controller states
  typedef enum logic [1:0] {
    IDLE,
    SEND_CMD,
    SEND_DATA,
    WAIT_RESP
  } ctrl_state_t;

endpackage

`default_nettype wire
